/* filelist.f */
lsu_pkg.sv
lsu.sv
bank_demux.sv
mem_bank.sv
bank_mux.sv
lsu_top.sv
lsu_top_assert.sv
tb_lsu_top.sv

/* tb_lsu_top.sv */
`timescale 1ns/1ns

module tb_lsu_top
  import lsu_pkg::*;
();

  localparam logic [ADDR_W-1:0] MEM_BYTES = 32'd1024;   // 4 banks of 64 words

  logic              clk;
  logic              rst;
  logic              lsu_receive_valid;
  logic              ren;
  logic              wen;
  logic              load_signed;
  logic [1:0]        load_size;
  logic [STRB_W-1:0] wstrb_in;
  logic [DATA_W-1:0] exu_result;
  logic [DATA_W-1:0] src2;
  logic [DATA_W-1:0] store_data;
  logic [1:0]        wd_op;
  logic [4:0]        rd_in;
  logic [ADDR_W-1:0] pc_in;
  logic              reg_write_en_in;
  logic              lsu_send_valid;
  logic [DATA_W-1:0] wd;
  logic [4:0]        rd;
  logic [ADDR_W-1:0] pc;
  logic              reg_write_en;
  logic              lsu_fault;
  logic              lsu_busy;

  logic [DATA_W-1:0] shadow [256];
  logic [31:0]       seed = 32'he4871587;
  logic [DATA_W-1:0] exp_wd;
  logic [ADDR_W-1:0] exp_pc;
  logic [4:0]        exp_rd;
  logic              exp_fault;
  logic              exp_wen;

  lsu_top #(
    .NUM_BANKS  (4),
    .BANK_WORDS (64)
  ) u_lsu_top (.*);

  always #20 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Random numbers and reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    seed = xorshift(seed);
    return seed;
  endfunction

  function automatic logic [DATA_W-1:0] ref_result(
    input  logic r, input logic w, input logic sgn, input logic [1:0] size,
    input  logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] op2,
    input  logic [1:0] op, input logic [ADDR_W-1:0] pc_val, output logic fault);
    load_word_u        word;
    logic [DATA_W-1:0] ld;
    fault = (r || w) && (addr >= MEM_BYTES);
    word  = load_word_u'(shadow[addr[9:2]]);
    case (size)
      SIZE_BYTE: ld = {{24{sgn && word.byte_lane[addr[1:0]][7]}}, word.byte_lane[addr[1:0]]};
      SIZE_HALF: ld = {{16{sgn && word.half_lane[addr[1]][15]}}, word.half_lane[addr[1]]};
      default:   ld = word;
    endcase
    case (op)
      WD_ALU:  return addr;
      WD_LOAD: return ld;
      WD_LINK: return pc_val + 32'd4;
      default: return op2;
    endcase
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic stop_with_fail();
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] want);
    if (got !== want) begin
      $display("mismatch time=%0t %s got=%h expected=%h", $time, name, got, want);
      stop_with_fail();
    end
  endtask

  task automatic check_reg(input string name, input logic [4:0] got, input logic [4:0] want);
    if (got !== want) begin
      $display("mismatch time=%0t %s got=%h expected=%h", $time, name, got, want);
      stop_with_fail();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("mismatch time=%0t %s got=%b expected=%b", $time, name, got, want);
      stop_with_fail();
    end
  endtask

  always @(negedge clk) begin
    if (u_lsu_top.u_lsu_top_assert.error_count != 0) begin
      $display("a bus protocol assertion failed at time %0t", $time);
      stop_with_fail();
    end
    if (!rst && lsu_send_valid) begin
      check_bit("lsu_fault", lsu_fault, exp_fault);
      check_bit("reg_write_en", reg_write_en, exp_wen);
      check_word("pc", pc, exp_pc);
      check_reg("rd", rd, exp_rd);
      if (!exp_fault) check_word("wd", wd, exp_wd);   // Faulted loads carry no data
    end
  end

  // One instruction from the upstream side, then wait for write-back
  task automatic run_op(input logic r, input logic w, input logic sgn, input logic [1:0] size,
                        input logic [STRB_W-1:0] strb, input logic [ADDR_W-1:0] addr,
                        input logic [DATA_W-1:0] data, input logic [1:0] op, input logic wr_in);
    logic fault;
    int   waited;
    @(negedge clk);
    check_bit("lsu_busy", lsu_busy, 1'b0);
    ren             = r;
    wen             = w;
    load_signed     = sgn;
    load_size       = size;
    wstrb_in        = strb;
    exu_result      = addr;
    store_data      = data;
    wd_op           = op;
    reg_write_en_in = wr_in;
    src2            = next_rand();
    pc_in           = next_rand() & 32'hffff_fffc;
    rd_in           = 5'(next_rand());
    exp_wd    = ref_result(r, w, sgn, size, addr, src2, op, pc_in, fault);
    exp_fault = fault;
    exp_wen   = wr_in && !fault;
    exp_pc    = pc_in;
    exp_rd    = rd_in;
    if (w && !r && !fault) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (strb[i]) shadow[addr[9:2]][8*i +: 8] = data[8*i +: 8];
      end
    end
    lsu_receive_valid = 1'b1;
    @(negedge clk);
    lsu_receive_valid = 1'b0;
    waited = 0;
    while (!lsu_send_valid) begin
      check_bit("lsu_busy", lsu_busy, 1'b1);
      if (waited == 50) begin
        $display("timeout: lsu_send_valid did not arrive within 50 cycles at %0t", $time);
        stop_with_fail();
      end
      @(negedge clk);
      waited++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    logic [ADDR_W-1:0] a;
    logic [1:0]        ops [3];
    ops = '{WD_ALU, WD_LINK, WD_SRC2};
    clk = 1'b0;
    rst = 1'b1;
    lsu_receive_valid = 1'b0;
    ren = 1'b0;
    wen = 1'b0;
    load_signed = 1'b0;
    load_size = SIZE_WORD;
    wstrb_in = '0;
    exu_result = '0;
    src2 = '0;
    store_data = '0;
    wd_op = WD_ALU;
    rd_in = '0;
    pc_in = '0;
    reg_write_en_in = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_bit("lsu_send_valid", lsu_send_valid, 1'b0);
      check_bit("lsu_busy", lsu_busy, 1'b0);
      check_bit("lsu_fault", lsu_fault, 1'b0);
    end
    for (int i = 0; i < 256; i++) begin           // Fill every word so no load sees X
      a = i * 4;
      run_op(0, 1, 0, SIZE_WORD, 4'hf, a, a * 32'h9e3779b1 + 32'h1234_5678, WD_ALU, 0);
    end
    for (int i = 0; i < 16; i++) run_op(1, 0, 0, SIZE_WORD, 0, i * 4, 0, WD_LOAD, 1);
    repeat (40) begin
      a = next_rand() & 32'h3fc;
      run_op(0, 1, 0, SIZE_WORD, 4'hf, a, next_rand(), WD_ALU, 0);
      run_op(1, 0, 0, SIZE_WORD, 0, a, 0, WD_LOAD, 1);
    end
    repeat (20) begin
      a = next_rand() & 32'h3fc;
      run_op(0, 1, 0, SIZE_WORD, 4'(next_rand()), a, next_rand(), WD_ALU, 0);
      for (int k = 0; k < 8; k++) run_op(1, 0, k[2], SIZE_BYTE, 0, a + k[1:0], 0, WD_LOAD, 1);
      for (int k = 0; k < 4; k++) begin
        run_op(1, 0, k[0], SIZE_HALF, 0, a + {k[1], 1'b0}, 0, WD_LOAD, 1);
      end
    end
    for (int k = 0; k < 3; k++) begin             // Full strobes would expose a stray write
      a = next_rand() & 32'h3fc;
      run_op(0, 0, 0, SIZE_WORD, 4'hf, a, next_rand(), ops[k], 1);
      run_op(1, 0, 0, SIZE_WORD, 0, a, 0, WD_LOAD, 1);
    end
    run_op(1, 0, 0, SIZE_WORD, 0, (32'h400 | next_rand()) & 32'hffff_fffc, 0, WD_LOAD, 1);
    run_op(0, 1, 0, SIZE_WORD, 4'hf, 32'h8000_0000, next_rand(), WD_ALU, 1);
    run_op(0, 1, 0, SIZE_WORD, 4'hf, 32'h10, next_rand(), WD_ALU, 0);
    run_op(1, 0, 1, SIZE_HALF, 0, 32'h12, 0, WD_LOAD, 1);
    repeat (2) @(negedge clk);
    if (u_lsu_top.u_lsu_top_assert.error_count == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("a bus protocol assertion failed during the run");
      stop_with_fail();
    end
  end

endmodule

/* lsu_top_assert.sv */
`timescale 1ns/1ns

module lsu_top_assert #(
  parameter int NUM_BANKS = 4
) (
  input logic                 clk,
  input logic                 rst,
  input logic                 arvalid,
  input logic                 arready,
  input logic                 awvalid,
  input logic                 awready,
  input logic                 wvalid,
  input logic                 wready,
  input logic                 lsu_send_valid,
  input logic [NUM_BANKS-1:0] bank_rvalid,
  input logic [NUM_BANKS-1:0] bank_bvalid
);

  int error_count = 0;   // Read by the testbench for its verdict

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid && !arready |=> arvalid)
    else begin
      error_count++;
      $error("arvalid dropped before arready");
    end

  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid && !(awready && wready) |=> awvalid && wvalid)
    else begin
      error_count++;
      $error("awvalid or wvalid dropped before both readies");
    end

  a_send_pulse: assert property (@(posedge clk) disable iff (rst)
    lsu_send_valid |=> !lsu_send_valid)
    else begin
      error_count++;
      $error("lsu_send_valid lasted more than one cycle");
    end

  // At most one bank answers at a time
  a_one_resp: assert property (@(posedge clk) disable iff (rst)
    $onehot0({bank_rvalid, bank_bvalid}))
    else begin
      error_count++;
      $error("more than one bank response asserted");
    end

endmodule

bind lsu_top lsu_top_assert #(.NUM_BANKS(NUM_BANKS)) u_lsu_top_assert (.*);

/* lsu_top.sv */
`timescale 1ns/1ns

module lsu_top
  import lsu_pkg::*;
#(
  parameter int NUM_BANKS  = 4,
  parameter int BANK_WORDS = 64
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              lsu_receive_valid,
  input  logic              ren,
  input  logic              wen,
  input  logic              load_signed,
  input  logic [1:0]        load_size,
  input  logic [STRB_W-1:0] wstrb_in,
  input  logic [DATA_W-1:0] exu_result,
  input  logic [DATA_W-1:0] src2,
  input  logic [DATA_W-1:0] store_data,
  input  logic [1:0]        wd_op,
  input  logic [4:0]        rd_in,
  input  logic [ADDR_W-1:0] pc_in,
  input  logic              reg_write_en_in,
  output logic              lsu_send_valid,
  output logic [DATA_W-1:0] wd,
  output logic [4:0]        rd,
  output logic [ADDR_W-1:0] pc,
  output logic              reg_write_en,
  output logic              lsu_fault,
  output logic              lsu_busy
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Master bus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic [ADDR_W-1:0] araddr;
  logic [ADDR_W-1:0] awaddr;
  logic [DATA_W-1:0] rdata;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic [1:0]        rresp;
  logic [1:0]        bresp;
  logic              arvalid;
  logic              arready;
  logic              rvalid;
  logic              rready;
  logic              awvalid;
  logic              awready;
  logic              wvalid;
  logic              wready;
  logic              bvalid;
  logic              bready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bank side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic [NUM_BANKS-1:0]             bank_arvalid;
  logic [NUM_BANKS-1:0]             bank_awvalid;
  logic [NUM_BANKS-1:0]             bank_wvalid;
  logic [NUM_BANKS-1:0]             bank_arready;
  logic [NUM_BANKS-1:0]             bank_awready;
  logic [NUM_BANKS-1:0]             bank_wready;
  logic [NUM_BANKS-1:0]             bank_rvalid;
  logic [NUM_BANKS-1:0]             bank_bvalid;
  logic [NUM_BANKS-1:0][DATA_W-1:0] bank_rdata;
  logic [$clog2(BANK_WORDS)-1:0]    word_addr;
  logic                             rd_miss;
  logic                             wr_miss;

  lsu u_lsu (.*);

  bank_demux #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_WORDS (BANK_WORDS)
  ) u_bank_demux (
    .bank_index (),
    .*
  );

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
    mem_bank #(
      .BANK_WORDS (BANK_WORDS)
    ) u_mem_bank (
      .clk     (clk),
      .rst     (rst),
      .ar_word (word_addr),
      .arvalid (bank_arvalid[i]),
      .aw_word (word_addr),
      .awvalid (bank_awvalid[i]),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wvalid  (bank_wvalid[i]),
      .rready  (rready),
      .bready  (bready),
      .arready (bank_arready[i]),
      .awready (bank_awready[i]),
      .wready  (bank_wready[i]),
      .rvalid  (bank_rvalid[i]),
      .rdata   (bank_rdata[i]),
      .bvalid  (bank_bvalid[i])
    );
  end

  bank_mux #(
    .NUM_BANKS (NUM_BANKS)
  ) u_bank_mux (.*);

endmodule

/* bank_mux.sv */
`timescale 1ns/1ns

module bank_mux
  import lsu_pkg::*;
#(
  parameter int NUM_BANKS = 4
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              rd_miss,
  input  logic                              wr_miss,
  input  logic [NUM_BANKS-1:0]              bank_rvalid,
  input  logic [NUM_BANKS-1:0][DATA_W-1:0]  bank_rdata,
  input  logic [NUM_BANKS-1:0]              bank_bvalid,
  input  logic                              rready,
  input  logic                              bready,
  output logic                              rvalid,
  output logic [DATA_W-1:0]                 rdata,
  output logic [1:0]                        rresp,
  output logic                              bvalid,
  output logic [1:0]                        bresp
);

  logic rd_err;
  logic wr_err;

  // Error responses stand in for the missing bank
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_err <= 1'b0;
      wr_err <= 1'b0;
    end else begin
      rd_err <= rd_miss || (rd_err && !rready);
      wr_err <= wr_miss || (wr_err && !bready);
    end
  end

  always_comb begin
    rdata = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (bank_rvalid[i]) begin
        rdata = rdata | bank_rdata[i];     // At most one bank answers
      end
    end
    rvalid = (|bank_rvalid) || rd_err;
    rresp  = rd_err ? RESP_SLVERR : RESP_OKAY;
    bvalid = (|bank_bvalid) || wr_err;
    bresp  = wr_err ? RESP_SLVERR : RESP_OKAY;
  end

endmodule

/* mem_bank.sv */
`timescale 1ns/1ns

module mem_bank
  import lsu_pkg::*;
#(
  parameter int BANK_WORDS = 64
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [$clog2(BANK_WORDS)-1:0] ar_word,
  input  logic                          arvalid,
  input  logic [$clog2(BANK_WORDS)-1:0] aw_word,
  input  logic                          awvalid,
  input  logic [DATA_W-1:0]             wdata,
  input  logic [STRB_W-1:0]             wstrb,
  input  logic                          wvalid,
  input  logic                          rready,
  input  logic                          bready,
  output logic                          arready,
  output logic                          awready,
  output logic                          wready,
  output logic                          rvalid,
  output logic [DATA_W-1:0]             rdata,
  output logic                          bvalid
);

  logic [DATA_W-1:0] ram [BANK_WORDS];
  logic              ar_hs;
  logic              w_hs;

  // A pending response blocks new requests until it is taken
  assign arready = !(rvalid || bvalid);
  assign awready = arready && !arvalid;    // Reads win a tie
  assign wready  = awready;

  assign ar_hs = arvalid && arready;
  assign w_hs  = awvalid && wvalid && awready && wready;

  always_ff @(posedge clk) begin
    if (w_hs) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (wstrb[i]) begin
          ram[aw_word][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
    if (ar_hs) begin
      rdata <= ram[ar_word];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      if (ar_hs) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
      if (w_hs) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

endmodule

/* bank_demux.sv */
`timescale 1ns/1ns

module bank_demux
  import lsu_pkg::*;
#(
  parameter int NUM_BANKS  = 4,
  parameter int BANK_WORDS = 64
) (
  input  logic [ADDR_W-1:0]             araddr,
  input  logic                          arvalid,
  input  logic [ADDR_W-1:0]             awaddr,
  input  logic                          awvalid,
  input  logic                          wvalid,
  output logic                          arready,
  output logic                          awready,
  output logic                          wready,
  input  logic [NUM_BANKS-1:0]          bank_arready,
  input  logic [NUM_BANKS-1:0]          bank_awready,
  input  logic [NUM_BANKS-1:0]          bank_wready,
  output logic [NUM_BANKS-1:0]          bank_arvalid,
  output logic [NUM_BANKS-1:0]          bank_awvalid,
  output logic [NUM_BANKS-1:0]          bank_wvalid,
  output logic [$clog2(NUM_BANKS)-1:0]  bank_index,
  output logic [$clog2(BANK_WORDS)-1:0] word_addr,
  output logic                          rd_miss,
  output logic                          wr_miss
);

  localparam int BANK_W = $clog2(NUM_BANKS);
  localparam int WORD_W = $clog2(BANK_WORDS);
  localparam logic [ADDR_W-1:0] MEM_BYTES = ADDR_W'(NUM_BANKS * BANK_WORDS * 4);

  logic [BANK_W-1:0] ar_bank;
  logic [BANK_W-1:0] aw_bank;
  logic              ar_miss;
  logic              aw_miss;

  assign ar_bank = araddr[2 +: BANK_W];    // Consecutive words go to neighbouring banks
  assign aw_bank = awaddr[2 +: BANK_W];
  assign ar_miss = (araddr >= MEM_BYTES);
  assign aw_miss = (awaddr >= MEM_BYTES);

  // Reads and writes never overlap, so one address path serves both
  assign bank_index = arvalid ? ar_bank : aw_bank;
  assign word_addr  = arvalid ? araddr[2+BANK_W +: WORD_W] : awaddr[2+BANK_W +: WORD_W];

  assign rd_miss = arvalid && ar_miss;
  assign wr_miss = awvalid && wvalid && aw_miss;

  assign arready = ar_miss || bank_arready[ar_bank];  // Unmapped requests go through at once
  assign awready = aw_miss || bank_awready[aw_bank];
  assign wready  = aw_miss || bank_wready[aw_bank];

  always_comb begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      bank_arvalid[i] = arvalid && !ar_miss && (ar_bank == BANK_W'(i));
      bank_awvalid[i] = awvalid && !aw_miss && (aw_bank == BANK_W'(i));
      bank_wvalid[i]  = wvalid && !aw_miss && (aw_bank == BANK_W'(i));
    end
  end

endmodule

/* lsu.sv */
`timescale 1ns/1ns

module lsu
  import lsu_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              lsu_receive_valid,
  input  logic              ren,
  input  logic              wen,
  input  logic              load_signed,
  input  logic [1:0]        load_size,
  input  logic [STRB_W-1:0] wstrb_in,
  input  logic [DATA_W-1:0] exu_result,
  input  logic [DATA_W-1:0] src2,
  input  logic [DATA_W-1:0] store_data,
  input  logic [1:0]        wd_op,
  input  logic [4:0]        rd_in,
  input  logic [ADDR_W-1:0] pc_in,
  input  logic              reg_write_en_in,
  input  logic              arready,
  input  logic [DATA_W-1:0] rdata,
  input  logic [1:0]        rresp,
  input  logic              rvalid,
  input  logic              awready,
  input  logic              wready,
  input  logic              bvalid,
  input  logic [1:0]        bresp,
  output logic              lsu_send_valid,
  output logic [DATA_W-1:0] wd,
  output logic [4:0]        rd,
  output logic [ADDR_W-1:0] pc,
  output logic              reg_write_en,
  output logic              lsu_fault,
  output logic              lsu_busy,
  output logic [ADDR_W-1:0] araddr,
  output logic              arvalid,
  output logic [ADDR_W-1:0] awaddr,
  output logic              awvalid,
  output logic [DATA_W-1:0] wdata,
  output logic [STRB_W-1:0] wstrb,
  output logic              wvalid,
  output logic              rready,
  output logic              bready
);

  localparam logic [2:0] IDLE       = 3'd0;
  localparam logic [2:0] READ_ADDR  = 3'd1;
  localparam logic [2:0] READ_DATA  = 3'd2;
  localparam logic [2:0] WRITE_REQ  = 3'd3;
  localparam logic [2:0] WRITE_RESP = 3'd4;
  localparam logic [2:0] DONE       = 3'd5;

  logic [2:0]        state;
  logic              accept;
  logic              r_hs;
  logic              b_hs;
  logic              bus_ready;
  logic              wr_en_q;
  logic [DATA_W-1:0] result_q;
  logic [DATA_W-1:0] src2_q;
  logic [1:0]        wd_op_q;
  logic              load_signed_q;
  logic [1:0]        load_size_q;
  logic [DATA_W-1:0] rdata_q;
  load_word_u        load_word;
  logic [7:0]        load_byte;
  logic [15:0]       load_half;
  logic [DATA_W-1:0] load_data;

  assign accept = (state == IDLE) && lsu_receive_valid;
  assign r_hs   = rvalid && rready;
  assign b_hs   = bvalid && bready;

  assign lsu_busy     = (state != IDLE);
  assign reg_write_en = wr_en_q && !lsu_fault;   // A faulted access never writes rd
  assign araddr       = result_q;
  assign awaddr       = result_q;
  assign rready       = bus_ready;
  assign bready       = bus_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control FSM and bus master
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= IDLE;
      arvalid        <= 1'b0;
      awvalid        <= 1'b0;
      wvalid         <= 1'b0;
      lsu_send_valid <= 1'b0;
      lsu_fault      <= 1'b0;
      wr_en_q        <= 1'b0;
      bus_ready      <= 1'b0;
    end else begin
      bus_ready <= 1'b1;
      case (state)
        IDLE: begin
          if (lsu_receive_valid) begin
            lsu_fault <= 1'b0;
            wr_en_q   <= reg_write_en_in;
            if (ren) begin                       // A load wins over a store
              state <= READ_ADDR;
            end else if (wen) begin
              state <= WRITE_REQ;
            end else begin
              state <= DONE;
            end
          end
        end
        READ_ADDR: begin
          if (!arvalid) begin
            arvalid <= 1'b1;
          end else if (arready) begin
            arvalid <= 1'b0;
            state   <= READ_DATA;
          end
        end
        READ_DATA: begin
          if (r_hs) begin
            lsu_fault <= (rresp != RESP_OKAY);
            state     <= DONE;
          end
        end
        WRITE_REQ: begin
          if (!awvalid) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
          end else if (awready && wready) begin   // AW and W retire together
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            state   <= WRITE_RESP;
          end
        end
        WRITE_RESP: begin
          if (b_hs) begin
            lsu_fault <= (bresp != RESP_OKAY);
            state     <= DONE;
          end
        end
        DONE: begin
          if (!lsu_send_valid) begin
            lsu_send_valid <= 1'b1;
          end else begin
            lsu_send_valid <= 1'b0;
            state          <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Operands are captured once and held through write-back
  always_ff @(posedge clk) begin
    if (accept) begin
      result_q      <= exu_result;
      src2_q        <= src2;
      wd_op_q       <= wd_op;
      load_signed_q <= load_signed;
      load_size_q   <= load_size;
      wdata         <= store_data;
      wstrb         <= wstrb_in;
      rd            <= rd_in;
      pc            <= pc_in;
    end
    if (state == READ_DATA && r_hs) begin
      rdata_q <= rdata;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Load extraction and write-back select
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    load_word = load_word_u'(rdata_q);
    load_byte = load_word.byte_lane[result_q[1:0]];
    load_half = load_word.half_lane[result_q[1]];
    case (load_size_q)
      SIZE_BYTE: load_data = {{(DATA_W-8){load_signed_q && load_byte[7]}}, load_byte};
      SIZE_HALF: load_data = {{(DATA_W-16){load_signed_q && load_half[15]}}, load_half};
      default:   load_data = rdata_q;              // Full word
    endcase
  end

  always_comb begin
    case (wd_op_q)
      WD_ALU:  wd = result_q;
      WD_LOAD: wd = load_data;
      WD_LINK: wd = pc + 32'd4;
      default: wd = src2_q;
    endcase
  end

endmodule

/* lsu_pkg.sv */
package lsu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus widths and response codes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_SLVERR = 2'd2;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write-back selection and load sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [1:0] WD_ALU  = 2'd0;    // Result from the execute stage
  localparam logic [1:0] WD_LOAD = 2'd1;    // Extracted load data
  localparam logic [1:0] WD_LINK = 2'd2;    // Return address of a jump
  localparam logic [1:0] WD_SRC2 = 2'd3;

  localparam logic [1:0] SIZE_BYTE = 2'd0;
  localparam logic [1:0] SIZE_HALF = 2'd1;
  localparam logic [1:0] SIZE_WORD = 2'd2;

  // One returned data word, read as byte lanes or as halfword lanes
  typedef union packed {
    logic [3:0][7:0]  byte_lane;
    logic [1:0][15:0] half_lane;
  } load_word_u;

endpackage
